// File: common/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

////////////////////////////////////////////////////////////
// execute stage widths
////////////////////////////////////////////////////////////

// full operand and result width, also the packed register width
`define EXEC_DATA_W 64

// scalar arithmetic path, upper bits of scalar results are zero
`define EXEC_SCALAR_W 32

// alu opcode field
`define EXEC_OP_W 5

`endif

// File: common/exec_pkg.sv
`include "exec_cfg.svh"

package exec_pkg;

    ////////////////////////////////////////////////////////////
    // opcodes and operand size
    ////////////////////////////////////////////////////////////

    typedef enum logic [`EXEC_OP_W-1:0] {
        op_and,
        op_or,
        op_not,
        op_mov_a,
        op_mov_b,
        op_cld,
        op_std,
        op_add,
        op_bsf,
        op_cmpxchg,
        op_daa,
        op_sal,
        op_sar,
        op_paddw,
        op_paddd,
        op_packsswb,
        op_packssdw,
        op_punpckhbw,
        op_punpckhw
    } alu_op_e;

    // picks sign bit and zero-test width
    typedef enum logic [1:0] {
        sz_byte,
        sz_word,
        sz_dword,
        sz_qword
    } op_size_e;

    ////////////////////////////////////////////////////////////
    // flags
    ////////////////////////////////////////////////////////////

    // eflags bits consumed by daa and the shifts
    typedef struct packed {
        logic af;
        logic cf;
        logic of;
    } in_flags_t;

    // per-unit flags, zf_own lets a unit override the zero test
    typedef struct packed {
        logic cf;
        logic af;
        logic of;
        logic zf_own;
        logic zf_val;
        logic cc_valid;
    } arith_flags_t;

    typedef struct packed {
        logic [`EXEC_DATA_W-1:0] result;
        arith_flags_t            flags;
    } unit_out_t;

    typedef struct packed {
        logic cf;
        logic pf;
        logic af;
        logic zf;
        logic sf;
        logic of;
        logic df;
    } flags_t;

    ////////////////////////////////////////////////////////////
    // request and response
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        alu_op_e                 op;
        op_size_e                size;
        logic                    shf_one;
        logic [`EXEC_DATA_W-1:0] op_a;
        logic [`EXEC_DATA_W-1:0] op_b;
        logic [`EXEC_DATA_W-1:0] op_c;
        in_flags_t               in_flags;
    } exec_req_t;

    typedef struct packed {
        logic [`EXEC_DATA_W-1:0] result;
        flags_t                  flags;
        logic                    cc_valid;
        logic                    swap;
    } exec_rsp_t;

endpackage

// File: alu/alu_int.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module alu_int import exec_pkg::*; (
    input  exec_req_t req,
    output unit_out_t out,
    output logic      swap
);
    localparam int DW = `EXEC_DATA_W;
    localparam int SW = `EXEC_SCALAR_W;
    localparam int IW = $clog2(SW);

    logic [SW-1:0] a_s;
    logic [SW-1:0] b_s;
    logic [SW-1:0] c_s;
    logic [SW:0]   add_sum;
    logic [SW:0]   cmp_diff;
    logic          cmp_eq;
    logic [IW-1:0] bsf_idx;
    logic          bsf_zero;
    logic [7:0]    al;
    logic [7:0]    al_adj;
    logic          daa_lo;
    logic          daa_hi;

    assign a_s = req.op_a[SW-1:0];
    assign b_s = req.op_b[SW-1:0];
    assign c_s = req.op_c[SW-1:0];

    // carry out lands in the extra top bit
    assign add_sum  = {1'b0, a_s} + {1'b0, b_s};
    // top bit is the borrow of a - c
    assign cmp_diff = {1'b0, a_s} - {1'b0, c_s};
    assign cmp_eq   = (a_s == c_s);

    assign swap = (req.op == op_cmpxchg) && cmp_eq;

    ////////////////////////////////////////////////////////////
    // bit scan forward
    ////////////////////////////////////////////////////////////

    // scan from the top so the lowest set bit wins
    always_comb begin
        bsf_idx = '0;
        for (int i = SW - 1; i >= 0; i--) begin
            if (a_s[i]) begin
                bsf_idx = IW'(i);
            end
        end
    end

    assign bsf_zero = (a_s == '0);

    ////////////////////////////////////////////////////////////
    // decimal adjust after add
    ////////////////////////////////////////////////////////////

    assign al     = req.op_a[7:0];
    assign daa_lo = (al[3:0] > 4'd9) || req.in_flags.af;
    // high correction looks at the original al, not the low-adjusted one
    assign daa_hi = (al > 8'h99) || req.in_flags.cf;
    assign al_adj = al + (daa_lo ? 8'h06 : 8'h00) + (daa_hi ? 8'h60 : 8'h00);

    ////////////////////////////////////////////////////////////
    // result and flag select
    ////////////////////////////////////////////////////////////

    always_comb begin
        out = '0;
        out.flags.cc_valid = 1'b1;
        case (req.op)
            op_and:   out.result = req.op_a & req.op_b;
            op_or:    out.result = req.op_a | req.op_b;
            op_not:   out.result = ~req.op_a;
            op_mov_a: out.result = req.op_a;
            op_mov_b: out.result = req.op_b;
            op_std:   out.result = DW'(1);
            op_add: begin
                out.result   = DW'(add_sum[SW-1:0]);
                out.flags.cf = add_sum[SW];
                out.flags.af = a_s[4] ^ b_s[4] ^ add_sum[4];
                // same-sign inputs with a flipped sign out
                out.flags.of = (a_s[SW-1] == b_s[SW-1]) && (add_sum[SW-1] != a_s[SW-1]);
            end
            op_bsf: begin
                out.result       = DW'(bsf_idx);
                out.flags.zf_own = 1'b1;
                out.flags.zf_val = bsf_zero;
            end
            op_cmpxchg: begin
                out.result       = cmp_eq ? DW'(b_s) : DW'(a_s);
                out.flags.cf     = cmp_diff[SW];
                out.flags.af     = a_s[4] ^ c_s[4] ^ cmp_diff[4];
                out.flags.of     = (a_s[SW-1] != c_s[SW-1]) &&
                                   (cmp_diff[SW-1] != a_s[SW-1]);
                out.flags.zf_own = 1'b1;
                out.flags.zf_val = cmp_eq;
            end
            op_daa: begin
                out.result   = DW'(al_adj);
                out.flags.af = daa_lo;
                out.flags.cf = daa_hi;
            end
            // cld and the non-integer opcodes give zero
            default: out.result = '0;
        endcase
    end

endmodule

// File: alu/alu_shift.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module alu_shift import exec_pkg::*; (
    input  exec_req_t req,
    output unit_out_t out
);
    localparam int DW = `EXEC_DATA_W;
    localparam int SW = `EXEC_SCALAR_W;
    localparam int CW = $clog2(SW);

    logic [SW-1:0] a_s;
    logic [CW-1:0] cnt;
    logic          over;
    logic          is_sar;
    logic [SW:0]   sal_ext;
    logic [SW:0]   sar_ext;
    logic [SW-1:0] res;
    logic          cf;
    logic          of;

    assign a_s    = req.op_a[SW-1:0];
    assign is_sar = (req.op == op_sar);
    assign cnt    = req.shf_one ? CW'(1) : req.op_b[CW-1:0];
    // count bits above the 5-bit field mean the shift clears everything
    assign over   = !req.shf_one && |req.op_b[7:CW];

    // extra bit catches the last bit shifted out
    assign sal_ext = {1'b0, a_s} << cnt;
    assign sar_ext = $signed({a_s, 1'b0}) >>> cnt;

    always_comb begin
        if (over) begin
            res = is_sar ? {SW{a_s[SW-1]}} : '0;
            cf  = is_sar & a_s[SW-1];
        end else if (is_sar) begin
            res = sar_ext[SW:1];
            cf  = sar_ext[0];
        end else begin
            res = sal_ext[SW-1:0];
            cf  = sal_ext[SW];
        end
    end

    // of is only defined for single-bit shifts, else keep the old value
    always_comb begin
        if (!over && cnt == CW'(1)) begin
            of = is_sar ? 1'b0 : (res[SW-1] ^ cf);
        end else begin
            of = req.in_flags.of;
        end
    end

    always_comb begin
        out                = '0;
        out.result         = DW'(res);
        out.flags.cf       = cf;
        out.flags.of       = of;
        // zero count leaves the flags untouched
        out.flags.cc_valid = over || (cnt != '0);
    end

endmodule

// File: alu/alu_simd.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module alu_simd import exec_pkg::*; (
    input  exec_req_t req,
    output unit_out_t out
);
    localparam int DW = `EXEC_DATA_W;

    logic [DW-1:0] paddw_r;
    logic [DW-1:0] paddd_r;
    logic [DW-1:0] packsswb_r;
    logic [DW-1:0] packssdw_r;
    logic [DW-1:0] punpckhbw_r;
    logic [DW-1:0] punpckhw_r;

    // signed word to signed byte with clamping
    function automatic logic [7:0] sat_w2b(input logic [15:0] w);
        if ($signed(w) > 16'sd127) begin
            return 8'h7f;
        end else if ($signed(w) < -16'sd128) begin
            return 8'h80;
        end
        return w[7:0];
    endfunction

    // signed dword to signed word with clamping
    function automatic logic [15:0] sat_d2w(input logic [31:0] d);
        if ($signed(d) > 32'sd32767) begin
            return 16'h7fff;
        end else if ($signed(d) < -32'sd32768) begin
            return 16'h8000;
        end
        return d[15:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // lane operations
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            paddw_r[16*i +: 16]       = req.op_a[16*i +: 16] + req.op_b[16*i +: 16];
            packsswb_r[8*i +: 8]      = sat_w2b(req.op_a[16*i +: 16]);
            packsswb_r[32+8*i +: 8]   = sat_w2b(req.op_b[16*i +: 16]);
            // op_a byte goes in the lower element
            punpckhbw_r[16*i +: 8]    = req.op_a[32+8*i +: 8];
            punpckhbw_r[16*i+8 +: 8]  = req.op_b[32+8*i +: 8];
        end
        for (int i = 0; i < 2; i++) begin
            paddd_r[32*i +: 32]       = req.op_a[32*i +: 32] + req.op_b[32*i +: 32];
            packssdw_r[16*i +: 16]    = sat_d2w(req.op_a[32*i +: 32]);
            packssdw_r[32+16*i +: 16] = sat_d2w(req.op_b[32*i +: 32]);
            punpckhw_r[32*i +: 16]    = req.op_a[32+16*i +: 16];
            punpckhw_r[32*i+16 +: 16] = req.op_b[32+16*i +: 16];
        end
    end

    always_comb begin
        out = '0;
        out.flags.cc_valid = 1'b1;
        case (req.op)
            op_paddw:     out.result = paddw_r;
            op_paddd:     out.result = paddd_r;
            op_packsswb:  out.result = packsswb_r;
            op_packssdw:  out.result = packssdw_r;
            op_punpckhbw: out.result = punpckhbw_r;
            op_punpckhw:  out.result = punpckhw_r;
            default:      out.result = '0;
        endcase
    end

endmodule

// File: rtl/result_merge.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module result_merge import exec_pkg::*; (
    input  alu_op_e                 op,
    input  op_size_e                size,
    input  unit_out_t               int_out,
    input  unit_out_t               shf_out,
    input  unit_out_t               simd_out,
    output logic [`EXEC_DATA_W-1:0] result,
    output flags_t                  flags,
    output logic                    cc_valid
);
    unit_out_t sel;
    logic      zf_size;
    logic      sf_size;

    // unit select by opcode group
    always_comb begin
        case (op)
            op_sal, op_sar: sel = shf_out;
            op_paddw, op_paddd, op_packsswb, op_packssdw,
            op_punpckhbw, op_punpckhw: sel = simd_out;
            default: sel = int_out;
        endcase
    end

    always_comb begin
        case (size)
            sz_byte: begin
                zf_size = (sel.result[7:0] == '0);
                sf_size = sel.result[7];
            end
            sz_word: begin
                zf_size = (sel.result[15:0] == '0);
                sf_size = sel.result[15];
            end
            sz_dword: begin
                zf_size = (sel.result[31:0] == '0);
                sf_size = sel.result[31];
            end
            default: begin
                zf_size = (sel.result == '0);
                sf_size = sel.result[`EXEC_DATA_W-1];
            end
        endcase
    end

    assign result   = sel.result;
    assign cc_valid = sel.flags.cc_valid;

    assign flags.cf = sel.flags.cf;
    // even parity of the low byte only
    assign flags.pf = ~^sel.result[7:0];
    assign flags.af = sel.flags.af;
    assign flags.zf = sel.flags.zf_own ? sel.flags.zf_val : zf_size;
    assign flags.sf = sf_size;
    assign flags.of = sel.flags.of;
    assign flags.df = (op == op_std);

endmodule

// File: rtl/exec_unit.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_unit import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    input  exec_req_t req,
    output logic      req_ready,
    output logic      rsp_valid,
    output exec_rsp_t rsp,
    input  logic      rsp_ready
);
    unit_out_t               int_out;
    unit_out_t               shf_out;
    unit_out_t               simd_out;
    logic                    swap;
    logic [`EXEC_DATA_W-1:0] result;
    flags_t                  flags;
    logic                    cc_valid;
    exec_rsp_t               rsp_d;
    logic                    req_fire;

    ////////////////////////////////////////////////////////////
    // combinational alu
    ////////////////////////////////////////////////////////////

    alu_int u_alu_int (
        .req  (req),
        .out  (int_out),
        .swap (swap)
    );

    alu_shift u_alu_shift (
        .req (req),
        .out (shf_out)
    );

    alu_simd u_alu_simd (
        .req (req),
        .out (simd_out)
    );

    result_merge u_result_merge (
        .op       (req.op),
        .size     (req.size),
        .int_out  (int_out),
        .shf_out  (shf_out),
        .simd_out (simd_out),
        .result   (result),
        .flags    (flags),
        .cc_valid (cc_valid)
    );

    assign rsp_d = '{result: result, flags: flags, cc_valid: cc_valid, swap: swap};

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    // slot frees up in the same cycle the consumer takes it
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (req_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp <= rsp_d;
        end
    end

endmodule

// File: verif/exec_unit_tb.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module exec_unit_tb import exec_pkg::*; ();

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_RAND        = 400;
    // upper bound on all directed and random requests
    localparam int NUM_REQ         = 800;
    localparam int WATCHDOG_CYCLES = NUM_REQ * 40 + 500;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    exec_req_t req;
    logic      req_ready;
    logic      rsp_valid;
    exec_rsp_t rsp;
    logic      rsp_ready;

    logic [31:0] rng_state = 32'hb87e42ec;
    logic        hold_ready;
    exec_rsp_t   exp_q[$];

    exec_unit dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // failure reporting
    ////////////////////////////////////////////////////////////

    task automatic halt_run();
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
        halt_run();
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        halt_run();
    endtask

    ////////////////////////////////////////////////////////////
    // random numbers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        hi = next_rand();
        return {hi, next_rand()};
    endfunction

    function automatic exec_req_t rand_req(input alu_op_e op);
        exec_req_t   r;
        logic [31:0] x;
        x = next_rand();
        r.op       = op;
        r.size     = op_size_e'(x[1:0]);
        r.shf_one  = 1'b0;
        r.in_flags = in_flags_t'(x[4:2]);
        r.op_a     = rand64();
        r.op_b     = rand64();
        r.op_c     = rand64();
        return r;
    endfunction

    function automatic alu_op_e rand_op();
        logic [31:0] x;
        logic [4:0]  k;
        x = next_rand();
        k = 5'(x % 19);
        return alu_op_e'(k);
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [7:0] clamp_byte(input logic [15:0] w);
        int v;
        v = int'($signed(w));
        if (v > 127) return 8'h7f;
        if (v < -128) return 8'h80;
        return w[7:0];
    endfunction

    function automatic logic [15:0] clamp_word(input logic [31:0] d);
        int v;
        v = int'($signed(d));
        if (v > 32767) return 16'h7fff;
        if (v < -32768) return 16'h8000;
        return d[15:0];
    endfunction

    function automatic logic out_of_int32(input longint v);
        return (v > longint'(32'sh7fffffff)) || (v < longint'(32'sh80000000));
    endfunction

    function automatic exec_rsp_t model(input exec_req_t r);
        exec_rsp_t   e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [32:0] wide;
        logic [7:0]  al;
        logic [4:0]  cnt;
        logic        over;
        logic        found;
        logic        zf_forced;
        logic        zf_v;
        int          msb;
        a          = r.op_a[31:0];
        b          = r.op_b[31:0];
        c          = r.op_c[31:0];
        e          = '0;
        e.cc_valid = 1'b1;
        zf_forced  = 1'b0;
        zf_v       = 1'b0;
        case (r.op)
            op_and:   e.result = r.op_a & r.op_b;
            op_or:    e.result = r.op_a | r.op_b;
            op_not:   e.result = ~r.op_a;
            op_mov_a: e.result = r.op_a;
            op_mov_b: e.result = r.op_b;
            op_cld:   e.result = 64'd0;
            op_std:   e.result = 64'd1;
            op_add: begin
                wide       = {1'b0, a} + {1'b0, b};
                e.result   = {32'h0, wide[31:0]};
                e.flags.cf = wide[32];
                e.flags.af = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
                e.flags.of = out_of_int32(longint'($signed(a)) + longint'($signed(b)));
            end
            op_bsf: begin
                found     = 1'b0;
                zf_forced = 1'b1;
                zf_v      = (a == 32'h0);
                for (int i = 0; i < 32; i++) begin
                    if (a[i] && !found) begin
                        e.result = 64'(i);
                        found    = 1'b1;
                    end
                end
            end
            op_cmpxchg: begin
                e.result   = (a == c) ? {32'h0, b} : {32'h0, a};
                e.swap     = (a == c);
                e.flags.cf = (a < c);
                e.flags.af = (a[3:0] < c[3:0]);
                e.flags.of = out_of_int32(longint'($signed(a)) - longint'($signed(c)));
                zf_forced  = 1'b1;
                zf_v       = (a == c);
            end
            op_daa: begin
                al         = r.op_a[7:0];
                e.flags.af = (al[3:0] > 4'd9) || r.in_flags.af;
                e.flags.cf = (al > 8'h99) || r.in_flags.cf;
                if (e.flags.af) al = al + 8'h06;
                if (e.flags.cf) al = al + 8'h60;
                e.result = {56'h0, al};
            end
            op_sal, op_sar: begin
                cnt        = r.shf_one ? 5'd1 : r.op_b[4:0];
                over       = !r.shf_one && (r.op_b[7:5] != 3'b000);
                e.flags.of = r.in_flags.of;
                e.cc_valid = over || (cnt != 5'd0);
                if (over) begin
                    e.flags.cf = (r.op == op_sar) && a[31];
                    e.result   = e.flags.cf ? 64'h0000_0000_ffff_ffff : 64'h0;
                end else if (cnt == 5'd0) begin
                    e.result = {32'h0, a};
                end else if (r.op == op_sal) begin
                    e.result   = {32'h0, a << cnt};
                    e.flags.cf = a[32 - cnt];
                    // result msb is a[30] when shifting by one
                    if (cnt == 5'd1) e.flags.of = a[31] ^ a[30];
                end else begin
                    e.result   = {32'h0, 32'($signed(a) >>> cnt)};
                    e.flags.cf = a[cnt - 1];
                    if (cnt == 5'd1) e.flags.of = 1'b0;
                end
            end
            op_paddw: begin
                for (int i = 0; i < 4; i++) begin
                    e.result[16*i +: 16] = r.op_a[16*i +: 16] + r.op_b[16*i +: 16];
                end
            end
            op_paddd: begin
                for (int i = 0; i < 2; i++) begin
                    e.result[32*i +: 32] = r.op_a[32*i +: 32] + r.op_b[32*i +: 32];
                end
            end
            op_packsswb: begin
                for (int i = 0; i < 4; i++) begin
                    e.result[8*i +: 8]      = clamp_byte(r.op_a[16*i +: 16]);
                    e.result[32 + 8*i +: 8] = clamp_byte(r.op_b[16*i +: 16]);
                end
            end
            op_packssdw: begin
                for (int i = 0; i < 2; i++) begin
                    e.result[16*i +: 16]      = clamp_word(r.op_a[32*i +: 32]);
                    e.result[32 + 16*i +: 16] = clamp_word(r.op_b[32*i +: 32]);
                end
            end
            op_punpckhbw: begin
                for (int i = 0; i < 4; i++) begin
                    e.result[16*i +: 8]     = r.op_a[32 + 8*i +: 8];
                    e.result[16*i + 8 +: 8] = r.op_b[32 + 8*i +: 8];
                end
            end
            op_punpckhw: begin
                for (int i = 0; i < 2; i++) begin
                    e.result[32*i +: 16]      = r.op_a[32 + 16*i +: 16];
                    e.result[32*i + 16 +: 16] = r.op_b[32 + 16*i +: 16];
                end
            end
            default: e.result = 64'h0;
        endcase
        // size width in bits is 8, 16, 32 or 64
        msb        = 8 * (1 << r.size) - 1;
        e.flags.sf = e.result[msb];
        e.flags.zf = zf_forced ? zf_v : ((e.result << (63 - msb)) == 64'h0);
        e.flags.pf = ~^e.result[7:0];
        e.flags.df = (r.op == op_std);
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////

    task automatic check_rsp(input exec_rsp_t got, input exec_rsp_t exp);
        assert (got.result === exp.result)
            else report_value("rsp.result", got.result, exp.result);
        assert (got.flags.cf === exp.flags.cf)
            else report_value("rsp.flags.cf", 64'(got.flags.cf), 64'(exp.flags.cf));
        assert (got.flags.pf === exp.flags.pf)
            else report_value("rsp.flags.pf", 64'(got.flags.pf), 64'(exp.flags.pf));
        assert (got.flags.af === exp.flags.af)
            else report_value("rsp.flags.af", 64'(got.flags.af), 64'(exp.flags.af));
        assert (got.flags.zf === exp.flags.zf)
            else report_value("rsp.flags.zf", 64'(got.flags.zf), 64'(exp.flags.zf));
        assert (got.flags.sf === exp.flags.sf)
            else report_value("rsp.flags.sf", 64'(got.flags.sf), 64'(exp.flags.sf));
        assert (got.flags.of === exp.flags.of)
            else report_value("rsp.flags.of", 64'(got.flags.of), 64'(exp.flags.of));
        assert (got.flags.df === exp.flags.df)
            else report_value("rsp.flags.df", 64'(got.flags.df), 64'(exp.flags.df));
        assert (got.cc_valid === exp.cc_valid)
            else report_value("rsp.cc_valid", 64'(got.cc_valid), 64'(exp.cc_valid));
        assert (got.swap === exp.swap)
            else report_value("rsp.swap", 64'(got.swap), 64'(exp.swap));
    endtask

    // older response leaves before the new request enters
    always @(posedge clk) begin
        if (rst_n) begin
            if (rsp_valid && rsp_ready) begin
                assert (exp_q.size() != 0) begin
                    check_rsp(rsp, exp_q.pop_front());
                end else begin
                    report_error("response seen with no accepted request");
                end
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(model(req));
                assert (exp_q.size() == 1)
                    else report_error("more than one response outstanding");
            end
        end
    end

    assert property (@(posedge clk) !rst_n |-> !rsp_valid)
        else report_error("rsp_valid high during reset");

    assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else report_error("response changed or dropped while stalled");

    assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |-> !req_ready)
        else report_error("req_ready high while output is stalled");

    assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && req_ready) |=> rsp_valid)
        else report_error("no response one cycle after an accepted request");

    ////////////////////////////////////////////////////////////
    // drivers
    ////////////////////////////////////////////////////////////

    task automatic step();
        logic [31:0] x;
        @(negedge clk);
        x = next_rand();
        rsp_ready = hold_ready || (x[1:0] != 2'b00);
    endtask

    // entered and left at a falling edge
    task automatic send(input exec_req_t r);
        logic taken;
        req        = r;
        req_valid  = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = req_ready;
            step();
        end
        req_valid = 1'b0;
    endtask

    task automatic run_logic_add();
        exec_req_t r;
        alu_op_e   ops[6] = '{op_and, op_or, op_not, op_mov_a, op_mov_b, op_add};
        logic [31:0] add_a[5] = '{32'h7fffffff, 32'hffffffff, 32'h0000000f, 0, 32'h80000000};
        logic [31:0] add_b[5] = '{32'h00000001, 32'h00000001, 32'h00000001, 0, 32'h80000000};
        foreach (ops[k]) begin
            for (int s = 0; s < 4; s++) begin
                repeat (3) begin
                    r      = rand_req(ops[k]);
                    r.size = op_size_e'(s[1:0]);
                    send(r);
                end
            end
        end
        foreach (add_a[k]) begin
            r             = rand_req(op_add);
            r.op_a[31:0]  = add_a[k];
            r.op_b[31:0]  = add_b[k];
            send(r);
        end
        // zero low byte with a non-zero upper part
        for (int s = 0; s < 4; s++) begin
            r      = rand_req(op_mov_a);
            r.size = op_size_e'(s[1:0]);
            r.op_a = 64'h0000_0000_0000_ff00;
            send(r);
        end
    endtask

    task automatic run_shifts();
        exec_req_t r;
        alu_op_e   ops[2] = '{op_sal, op_sar};
        foreach (ops[k]) begin
            repeat (6) begin
                for (int n = 0; n < 6; n++) begin
                    r            = rand_req(ops[k]);
                    r.op_b[7:5]  = 3'b000;
                    case (n)
                        0: r.op_b[4:0] = 5'd0;
                        1: r.op_b[4:0] = 5'd1;
                        3: r.op_b[7:5] = 3'b100;
                        4: r.shf_one   = 1'b1;
                        5: r.op_b[4:0] = 5'd31;
                        default: ;
                    endcase
                    send(r);
                end
            end
        end
    endtask

    task automatic run_packed();
        exec_req_t r;
        alu_op_e   ops[6] = '{op_paddw, op_paddd, op_packsswb, op_packssdw,
                              op_punpckhbw, op_punpckhw};
        foreach (ops[k]) begin
            repeat (6) begin
                send(rand_req(ops[k]));
            end
        end
        // both signed limits and the values just inside them
        r      = rand_req(op_packsswb);
        r.op_a = {16'h7fff, 16'h8000, 16'h007f, 16'hff80};
        r.op_b = {16'h0080, 16'hff7f, 16'h0000, 16'hffff};
        send(r);
        r      = rand_req(op_packssdw);
        r.op_a = {32'h7fffffff, 32'h80000000};
        r.op_b = {32'h00008000, 32'hffff7fff};
        send(r);
        r      = rand_req(op_packssdw);
        r.op_a = {32'h00007fff, 32'hffff8000};
        r.op_b = {32'h00000000, 32'hffffffff};
        send(r);
    endtask

    task automatic run_misc();
        exec_req_t   r;
        logic [31:0] bsf_in[4] = '{32'h0, 32'h1, 32'h0001_0000, 32'h8000_0000};
        logic [7:0]  al_vals[6] = '{8'h09, 8'h0a, 8'h99, 8'h9a, 8'hff, 8'h45};
        foreach (bsf_in[k]) begin
            r            = rand_req(op_bsf);
            r.op_a[31:0] = bsf_in[k];
            send(r);
            send(rand_req(op_bsf));
        end
        repeat (3) begin
            r            = rand_req(op_cmpxchg);
            r.op_c[31:0] = r.op_a[31:0];
            send(r);
            send(rand_req(op_cmpxchg));
        end
        foreach (al_vals[k]) begin
            for (int f = 0; f < 4; f++) begin
                r             = rand_req(op_daa);
                r.op_a[7:0]   = al_vals[k];
                r.in_flags.af = f[1];
                r.in_flags.cf = f[0];
                send(r);
            end
        end
        repeat (2) begin
            send(rand_req(op_cld));
            send(rand_req(op_std));
        end
    endtask

    task automatic run_back_to_back();
        hold_ready = 1'b1;
        step();
        repeat (20) begin
            send(rand_req(rand_op()));
        end
        hold_ready = 1'b0;
    endtask

    task automatic run_random();
        exec_req_t   r;
        logic [31:0] x;
        repeat (NUM_RAND) begin
            r = rand_req(rand_op());
            x = next_rand();
            r.shf_one = (x[1:0] == 2'b00);
            if (x[2]) r.op_b[7:5] = 3'b000;
            send(r);
            repeat (x[4:3] == 2'b11 ? 2 : 0) step();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b0;
        hold_ready = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (!rsp_valid) else report_error("rsp_valid high after reset");

        run_logic_add();
        run_shifts();
        run_packed();
        run_misc();
        run_back_to_back();
        run_random();

        hold_ready = 1'b1;
        while (rsp_valid || exp_q.size() != 0) begin
            step();
        end
        $display("** PASS **");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_error("watchdog expired before all responses arrived");
    end

endmodule

// File: exec_unit.f
+incdir+common
common/exec_pkg.sv
alu/alu_int.sv
alu/alu_shift.sv
alu/alu_simd.sv
rtl/result_merge.sv
rtl/exec_unit.sv
verif/exec_unit_tb.sv

// File: Bender.yml
package:
  name: exec_unit

export_include_dirs:
  - common

sources:
  # design sources in compile order
  - include_dirs:
      - common
    files:
      - common/exec_pkg.sv
      - alu/alu_int.sv
      - alu/alu_shift.sv
      - alu/alu_simd.sv
      - rtl/result_merge.sv
      - rtl/exec_unit.sv

  # testbench with top module exec_unit_tb
  - target: test
    include_dirs:
      - common
    files:
      - verif/exec_unit_tb.sv
